/* common/mips_pkg.sv */
package mips_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////////////////////

	// Major opcodes, IR[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_addiu = 6'h09,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// R-type functions, IR[5:0]
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_t;

	// What the FSM asks of the ALU
	typedef enum logic [1:0] {
		class_add   = 2'd0,
		class_sub   = 2'd1,
		class_funct = 2'd2
	} alu_class_t;

	typedef enum logic [3:0] {
		alu_and = 4'd0,
		alu_or  = 4'd1,
		alu_add = 4'd2,
		alu_sub = 4'd6,
		alu_slt = 4'd7,
		alu_sll = 4'd8
	} alu_ctrl_t;

	////////////////////////////////////////////////////////////////////////////
	// Datapath select codes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [1:0] SRC_A_PC    = 2'd0;
	localparam logic [1:0] SRC_A_REG_A = 2'd1;
	localparam logic [1:0] SRC_A_REG_B = 2'd2;

	localparam logic [2:0] SRC_B_REG_B  = 3'd0;
	localparam logic [2:0] SRC_B_FOUR   = 3'd1;
	localparam logic [2:0] SRC_B_IMM    = 3'd2;
	localparam logic [2:0] SRC_B_IMM_SH = 3'd3;
	localparam logic [2:0] SRC_B_SHAMT  = 3'd4;

	localparam logic [1:0] PC_SRC_ALU     = 2'd0;
	localparam logic [1:0] PC_SRC_ALU_OUT = 2'd1;
	localparam logic [1:0] PC_SRC_JUMP    = 2'd2;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       ir_write;
		logic       mem_write;
		logic       mem_to_reg;
		logic       reg_dst;
		logic       reg_write;
		logic       pc_write;
		logic       pc_write_cond;
		logic       i_or_d;
		logic [1:0] alu_src_a;
		logic [1:0] pc_source;
		logic [2:0] alu_src_b;
		alu_class_t alu_class;
	} ctrl_t;

	typedef struct packed {
		logic  write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

endpackage

/* logic/alu.sv */
module alu (
	input  mips_pkg::word_t      a,
	input  mips_pkg::word_t      b,
	input  mips_pkg::alu_class_t alu_class,
	input  mips_pkg::funct_t     funct,
	output mips_pkg::word_t      result,
	output logic                 zero
);
	import mips_pkg::*;

	alu_ctrl_t op;

	// Class and funct to operation
	always_comb begin
		case (alu_class)
			class_add: op = alu_add;
			class_sub: op = alu_sub;
			default: begin
				case (funct)
					fn_addu: op = alu_add;
					fn_subu: op = alu_sub;
					fn_and:  op = alu_and;
					fn_or:   op = alu_or;
					fn_slt:  op = alu_slt;
					fn_sll:  op = alu_sll;
					default: op = alu_add;
				endcase
			end
		endcase
	end

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {31'd0, $signed(a) < $signed(b)};
			// rt arrives on a, shamt on b
			alu_sll: result = a << b[4:0];
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* logic/register_file.sv */
module register_file (
	input  logic                clk,
	input  logic                reset,
	input  mips_pkg::reg_addr_t rd_addr1,
	input  mips_pkg::reg_addr_t rd_addr2,
	input  mips_pkg::reg_addr_t wr_addr,
	input  mips_pkg::word_t     wr_data,
	input  logic                wr_ena,
	output mips_pkg::word_t     rd_data1,
	output mips_pkg::word_t     rd_data2
);
	import mips_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ena && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Register 0 is hard wired
	assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
	assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

/* core/control_fsm.sv */
module control_fsm (
	input  logic              clk,
	input  logic              reset,
	input  mips_pkg::opcode_t opcode,
	input  mips_pkg::funct_t  funct,
	output mips_pkg::ctrl_t   ctrl
);
	import mips_pkg::*;

	typedef enum logic [3:0] {
		fetch,
		decode,
		mem_addr,
		mem_read,
		mem_wb,
		mem_store,
		exec_r,
		exec_i,
		alu_wb,
		branch,
		jump
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetch;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			fetch: state_next = decode;
			decode: begin
				case (opcode)
					op_lw,
					op_sw:    state_next = mem_addr;
					op_rtype: state_next = exec_r;
					op_addiu: state_next = exec_i;
					op_beq:   state_next = branch;
					op_j:     state_next = jump;
					// Anything else is dropped
					default:  state_next = fetch;
				endcase
			end
			mem_addr:  state_next = (opcode == op_lw) ? mem_read : mem_store;
			mem_read:  state_next = mem_wb;
			exec_r,
			exec_i:    state_next = alu_wb;
			default:   state_next = fetch;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		case (state)
			fetch: begin
				// IR <= mem[PC], PC <= PC + 4
				ctrl.ir_write  = 1'b1;
				ctrl.pc_write  = 1'b1;
				ctrl.alu_src_a = SRC_A_PC;
				ctrl.alu_src_b = SRC_B_FOUR;
				ctrl.pc_source = PC_SRC_ALU;
				ctrl.alu_class = class_add;
			end
			decode: begin
				// Branch target into ALUOut ahead of time
				ctrl.alu_src_a = SRC_A_PC;
				ctrl.alu_src_b = SRC_B_IMM_SH;
				ctrl.alu_class = class_add;
			end
			mem_addr,
			exec_i: begin
				ctrl.alu_src_a = SRC_A_REG_A;
				ctrl.alu_src_b = SRC_B_IMM;
				ctrl.alu_class = class_add;
			end
			mem_read: begin
				ctrl.i_or_d = 1'b1;
			end
			mem_wb: begin
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			mem_store: begin
				ctrl.i_or_d    = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			exec_r: begin
				ctrl.alu_class = class_funct;
				// sll takes rt from B and shamt from the immediate field
				if (funct == fn_sll) begin
					ctrl.alu_src_a = SRC_A_REG_B;
					ctrl.alu_src_b = SRC_B_SHAMT;
				end else begin
					ctrl.alu_src_a = SRC_A_REG_A;
					ctrl.alu_src_b = SRC_B_REG_B;
				end
			end
			alu_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = (opcode == op_rtype);
			end
			branch: begin
				ctrl.pc_write_cond = 1'b1;
				ctrl.alu_src_a     = SRC_A_REG_A;
				ctrl.alu_src_b     = SRC_B_REG_B;
				ctrl.alu_class     = class_sub;
				ctrl.pc_source     = PC_SRC_ALU_OUT;
			end
			jump: begin
				ctrl.pc_write  = 1'b1;
				ctrl.pc_source = PC_SRC_JUMP;
			end
			default: ctrl = '0;
		endcase
		// Nothing is driven while reset is held
		if (reset) begin
			ctrl = '0;
		end
	end

endmodule

/* core/mips_core.sv */
module mips_core (
	input  logic               clk,
	input  logic               reset,
	input  mips_pkg::word_t    read_data,
	output mips_pkg::mem_req_t mem_req
);
	import mips_pkg::*;

	// Control from the FSM
	ctrl_t ctrl;

	// Datapath registers
	word_t ir;
	word_t mdr;
	word_t reg_a;
	word_t reg_b;
	word_t alu_out;
	word_t pc;

	// Instruction fields
	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     imm_ext;
	word_t     imm_shifted;
	word_t     shamt_ext;
	word_t     jump_addr;

	// Register file and ALU hookup
	reg_addr_t wr_addr;
	word_t     wr_data;
	word_t     rd_data1;
	word_t     rd_data2;
	word_t     alu_in_a;
	word_t     alu_in_b;
	word_t     alu_result;
	logic      alu_zero;

	// PC update
	logic  pc_en;
	word_t pc_next;

	////////////////////////////////////////////////////////////////////////////
	// Decode of the held instruction
	////////////////////////////////////////////////////////////////////////////

	assign opcode      = opcode_t'(ir[31:26]);
	assign funct       = funct_t'(ir[5:0]);
	assign rs          = ir[25:21];
	assign rt          = ir[20:16];
	assign rd          = ir[15:11];
	assign imm_ext     = {{16{ir[15]}}, ir[15:0]};
	assign imm_shifted = {imm_ext[29:0], 2'b00};
	assign shamt_ext   = {27'd0, ir[10:6]};
	// Upper bits come from the already incremented PC
	assign jump_addr   = {pc[31:28], ir[25:0], 2'b00};

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ir      <= '0;
			mdr     <= '0;
			reg_a   <= '0;
			reg_b   <= '0;
			alu_out <= '0;
			pc      <= '0;
		end else begin
			if (ctrl.ir_write) begin
				ir <= read_data;
			end
			mdr     <= read_data;
			reg_a   <= rd_data1;
			reg_b   <= rd_data2;
			alu_out <= alu_result;
			if (pc_en) begin
				pc <= pc_next;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Muxes
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ctrl.alu_src_a)
			SRC_A_PC:    alu_in_a = pc;
			SRC_A_REG_A: alu_in_a = reg_a;
			default:     alu_in_a = reg_b;
		endcase
	end

	always_comb begin
		case (ctrl.alu_src_b)
			SRC_B_REG_B:  alu_in_b = reg_b;
			SRC_B_FOUR:   alu_in_b = 32'd4;
			SRC_B_IMM:    alu_in_b = imm_ext;
			SRC_B_IMM_SH: alu_in_b = imm_shifted;
			default:      alu_in_b = shamt_ext;
		endcase
	end

	always_comb begin
		case (ctrl.pc_source)
			PC_SRC_ALU:     pc_next = alu_result;
			PC_SRC_ALU_OUT: pc_next = alu_out;
			default:        pc_next = jump_addr;
		endcase
	end

	// Branch taken only when the compare gives zero
	assign pc_en = ctrl.pc_write | (ctrl.pc_write_cond & alu_zero);

	assign wr_addr = ctrl.reg_dst ? rd : rt;
	assign wr_data = ctrl.mem_to_reg ? mdr : alu_out;

	assign mem_req.write = ctrl.mem_write;
	assign mem_req.addr  = ctrl.i_or_d ? alu_out : pc;
	assign mem_req.wdata = reg_b;

	////////////////////////////////////////////////////////////////////////////
	// Submodules
	////////////////////////////////////////////////////////////////////////////

	control_fsm u_control_fsm (
		.clk    (clk),
		.reset  (reset),
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (ctrl)
	);

	register_file u_register_file (
		.clk      (clk),
		.reset    (reset),
		.rd_addr1 (rs),
		.rd_addr2 (rt),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_ena   (ctrl.reg_write),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	alu u_alu (
		.a         (alu_in_a),
		.b         (alu_in_b),
		.alu_class (ctrl.alu_class),
		.funct     (funct),
		.result    (alu_result),
		.zero      (alu_zero)
	);

endmodule

/* logic/unified_memory.sv */
module unified_memory #(
	parameter int MEM_WORDS = 256
) (
	input  logic               clk,
	input  mips_pkg::mem_req_t core_req,
	input  logic               load_we,
	input  mips_pkg::word_t    load_addr,
	input  mips_pkg::word_t    load_data,
	output mips_pkg::word_t    read_data
);
	import mips_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	word_t mem [MEM_WORDS];

	logic [IDX_W-1:0] core_idx;
	logic [IDX_W-1:0] load_idx;

	// Byte address to word index, wrapping at the memory size
	assign core_idx = IDX_W'((core_req.addr >> 2) % MEM_WORDS);
	assign load_idx = IDX_W'((load_addr >> 2) % MEM_WORDS);

	// Program load wins over a core store
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_idx] <= load_data;
		end else if (core_req.write) begin
			mem[core_idx] <= core_req.wdata;
		end
	end

	assign read_data = mem[core_idx];

endmodule

/* logic/mips_system.sv */
module mips_system #(
	parameter int MEM_WORDS = 256
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               load_we,
	input  mips_pkg::word_t    load_addr,
	input  mips_pkg::word_t    load_data,
	output mips_pkg::mem_req_t mem_req
);
	import mips_pkg::*;

	mem_req_t core_req;
	word_t    read_data;

	mips_core u_mips_core (
		.clk       (clk),
		.reset     (reset),
		.read_data (read_data),
		.mem_req   (core_req)
	);

	unified_memory #(
		.MEM_WORDS (MEM_WORDS)
	) u_unified_memory (
		.clk       (clk),
		.core_req  (core_req),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.read_data (read_data)
	);

	// Stores are visible at the top
	assign mem_req = core_req;

endmodule

/* tb/mips_properties.sv */
module mips_properties (
	input logic               clk,
	input logic               reset,
	input mips_pkg::mem_req_t mem_req
);
	timeunit 1ns;
	timeprecision 1ps;

	int failures = 0;

	// Memory must stay untouched by the core during reset
	no_store_in_reset: assert property (@(posedge clk) reset |-> !mem_req.write)
		else begin
			failures++;
			$error("store request while reset is high");
		end

	store_aligned: assert property (@(posedge clk) disable iff (reset)
		mem_req.write |-> (mem_req.addr[1:0] == 2'b00))
		else begin
			failures++;
			$error("store address %h is not word aligned", mem_req.addr);
		end

	write_known: assert property (@(posedge clk) !reset |-> !$isunknown(mem_req.write))
		else begin
			failures++;
			$error("store strobe is unknown");
		end

endmodule

bind mips_system mips_properties u_mips_properties (
	.clk     (clk),
	.reset   (reset),
	.mem_req (mem_req)
);

/* tb/mips_checker.sv */
module mips_checker #(
	parameter int MEM_WORDS = 256
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               load_we,
	input  mips_pkg::word_t    load_addr,
	input  mips_pkg::word_t    load_data,
	input  mips_pkg::mem_req_t mem_req,
	output logic               run_done,
	output int                 value_errors,
	output int                 extra_stores,
	output int                 reset_stores
);
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;

	// Copy of memory as loaded, then updated by the model
	word_t image [MEM_WORDS];
	word_t regs [32];
	word_t exp_addr [$];
	word_t exp_data [$];
	logic  armed;
	logic  built;
	int    store_index;

	initial begin
		run_done     = 1'b0;
		value_errors = 0;
		extra_stores = 0;
		reset_stores = 0;
		armed        = 1'b0;
		built        = 1'b0;
		store_index  = 0;
	end

	function automatic int word_index(word_t addr);
		return int'((addr >> 2) % MEM_WORDS);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Instruction-level model, from address 0 to the final self jump
	////////////////////////////////////////////////////////////////////////////

	task automatic predict_stores();
		word_t     instr;
		word_t     pc;
		word_t     pc_next;
		word_t     imm;
		word_t     addr;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic      halted;
		int        steps;
		exp_addr.delete();
		exp_data.delete();
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		pc     = '0;
		halted = 1'b0;
		steps  = 0;
		while (!halted && steps < 4 * MEM_WORDS) begin
			instr   = image[word_index(pc)];
			rs      = instr[25:21];
			rt      = instr[20:16];
			rd      = instr[15:11];
			imm     = {{16{instr[15]}}, instr[15:0]};
			addr    = regs[rs] + imm;
			pc_next = pc + 32'd4;
			case (instr[31:26])
				op_rtype: begin
					case (instr[5:0])
						fn_addu: regs[rd] = regs[rs] + regs[rt];
						fn_subu: regs[rd] = regs[rs] - regs[rt];
						fn_and:  regs[rd] = regs[rs] & regs[rt];
						fn_or:   regs[rd] = regs[rs] | regs[rt];
						fn_slt: begin
							regs[rd] = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
						end
						fn_sll:  regs[rd] = regs[rt] << instr[10:6];
						default: regs[rd] = regs[rd];
					endcase
				end
				op_addiu: regs[rt] = regs[rs] + imm;
				op_lw:    regs[rt] = image[word_index(addr)];
				op_sw: begin
					image[word_index(addr)] = regs[rt];
					exp_addr.push_back(addr);
					exp_data.push_back(regs[rt]);
				end
				op_beq: begin
					if (regs[rs] == regs[rt]) begin
						pc_next = pc + 32'd4 + (imm << 2);
					end
				end
				op_j: begin
					pc_next = {pc_next[31:28], instr[25:0], 2'b00};
					halted  = (pc_next == pc);
				end
				default: pc_next = pc + 32'd4;
			endcase
			regs[0] = '0;
			pc      = pc_next;
			steps++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Load capture and store compare
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			if (load_we) begin
				image[word_index(load_addr)] = load_data;
			end
			if (mem_req.write) begin
				reset_stores++;
				$display("%0d ns: store request seen while reset is held", $time);
			end
			armed    = 1'b1;
			built    = 1'b0;
			run_done = 1'b0;
		end else begin
			if (armed) begin
				predict_stores();
				store_index = 0;
				armed       = 1'b0;
				built       = 1'b1;
			end
			if (mem_req.write) begin
				if (exp_addr.size() == 0) begin
					extra_stores++;
					$display("%0d ns: store to %h arrived after all expected stores", $time,
						mem_req.addr);
				end else begin
					if (mem_req.addr !== exp_addr[0] || mem_req.wdata !== exp_data[0]) begin
						value_errors++;
						$display("[ERROR] %0d ns: store %0d wrote %h to %h, expected %h to %h",
							$time, store_index, mem_req.wdata, mem_req.addr,
							exp_data[0], exp_addr[0]);
					end
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
					store_index++;
				end
			end
			run_done = built && (exp_addr.size() == 0);
		end
	end

endmodule

/* tb/tb_mips_system.sv */
module tb_mips_system;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;

	localparam int MEM_WORDS    = 256;
	localparam int CODE_WORDS   = 128;
	localparam int PROG_LEN     = 40;
	localparam int RUNS         = 20;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 20;
	localparam int CYCLE_LIMIT  = RUNS * (RESET_CYCLES + MEM_WORDS + PROG_LEN * 5 + 50);
	localparam logic [31:0] SEED = 32'hd45e9e79;

	logic     clk;
	logic     reset;
	logic     load_we;
	word_t    load_addr;
	word_t    load_data;
	mem_req_t mem_req;

	logic run_done;
	int   value_errors;
	int   extra_stores;
	int   reset_stores;
	int   assert_failures;
	int   run_index;
	int   cycle_count;

	word_t code [CODE_WORDS];

	mips_system #(
		.MEM_WORDS (MEM_WORDS)
	) u_mips_system (
		.clk       (clk),
		.reset     (reset),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.mem_req   (mem_req)
	);

	mips_checker #(
		.MEM_WORDS (MEM_WORDS)
	) u_mips_checker (
		.clk          (clk),
		.reset        (reset),
		.load_we      (load_we),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.mem_req      (mem_req),
		.run_done     (run_done),
		.value_errors (value_errors),
		.extra_stores (extra_stores),
		.reset_stores (reset_stores)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t rtype_word(funct_t fn, reg_addr_t rs, reg_addr_t rt,
			reg_addr_t rd, logic [4:0] shamt);
		return {op_rtype, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t itype_word(opcode_t op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(int target);
		return {op_j, 26'(target)};
	endfunction

	// Aligned byte offset into the low part of the data region
	function automatic logic [15:0] data_offset();
		return 16'h0200 + 16'(4 * ($urandom % 48));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Program generation and loading
	////////////////////////////////////////////////////////////////////////////

	task automatic build_program();
		int        i;
		int        kind;
		int        target;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		reg_addr_t dest;
		i = 0;
		while (i < PROG_LEN - 1) begin
			kind = $urandom % 11;
			// Pairs need two slots before the final self jump
			if (kind <= 7 && i >= PROG_LEN - 2) begin
				kind = 8;
			end
			rs = 5'($urandom % 8);
			rt = 5'($urandom % 8);
			rd = 5'($urandom % 8);
			dest = rd;
			case (kind)
				0: code[i] = rtype_word(fn_addu, rs, rt, rd, 5'd0);
				1: code[i] = rtype_word(fn_subu, rs, rt, rd, 5'd0);
				2: code[i] = rtype_word(fn_and, rs, rt, rd, 5'd0);
				3: code[i] = rtype_word(fn_or, rs, rt, rd, 5'd0);
				4: code[i] = rtype_word(fn_slt, rs, rt, rd, 5'd0);
				5: code[i] = rtype_word(fn_sll, 5'd0, rt, rd, 5'($urandom % 32));
				6: begin
					code[i] = itype_word(op_addiu, rs, rt, 16'($urandom));
					dest = rt;
				end
				7: begin
					code[i] = itype_word(op_lw, 5'd0, rt, data_offset());
					dest = rt;
				end
				8: code[i] = itype_word(op_sw, 5'd0, rt, data_offset());
				9: begin
					// Equal operands about half the time
					if ($urandom % 2) begin
						rt = rs;
					end
					target = i + 1 + int'($urandom % (PROG_LEN - 1 - i));
					code[i] = itype_word(op_beq, rs, rt, 16'(target - i - 1));
				end
				default: begin
					target = i + 1 + int'($urandom % (PROG_LEN - 1 - i));
					code[i] = jump_word(target);
				end
			endcase
			if (kind <= 7) begin
				code[i + 1] = itype_word(op_sw, 5'd0, dest, data_offset());
				i = i + 2;
			end else begin
				i = i + 1;
			end
		end
		code[PROG_LEN - 1] = jump_word(PROG_LEN - 1);
		// Unused code words, opcode 0x3f plus the byte address
		for (int w = PROG_LEN; w < CODE_WORDS; w++) begin
			code[w] = 32'hfc00_0000 | word_t'(w * 4);
		end
	endtask

	// One word per cycle, code first, then random data
	task automatic load_memory();
		for (int w = 0; w < MEM_WORDS; w++) begin
			@(negedge clk);
			load_we   = 1'b1;
			load_addr = word_t'(w * 4);
			load_data = (w < CODE_WORDS) ? code[w] : word_t'($urandom);
		end
		@(negedge clk);
		load_we = 1'b0;
	endtask

	task automatic wait_for_stores();
		while (!run_done) begin
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset     = 1'b1;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		run_index = 0;
		void'($urandom(SEED));
		for (run_index = 0; run_index < RUNS; run_index++) begin
			@(negedge clk);
			reset = 1'b1;
			build_program();
			load_memory();
			repeat (RESET_CYCLES) @(negedge clk);
			reset = 1'b0;
			wait_for_stores();
			// Let the final self jump spin to expose stray stores
			repeat (DRAIN_CYCLES) @(negedge clk);
		end
		assert_failures = u_mips_system.u_mips_properties.failures;
		$display("Errors: %0d mismatch, %0d extra store, %0d reset store, %0d assertion",
			value_errors, extra_stores, reset_stores, assert_failures);
		if (value_errors + extra_stores + reset_stores + assert_failures == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run %0d did not deliver all its stores within %0d cycles",
			run_index, CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* filelist.f */
common/mips_pkg.sv
logic/alu.sv
logic/register_file.sv
core/control_fsm.sv
core/mips_core.sv
logic/unified_memory.sv
logic/mips_system.sv
tb/mips_properties.sv
tb/mips_checker.sv
tb/tb_mips_system.sv

/* Bender.yml */
package:
  name: mips_system

sources:
  - files:
      - common/mips_pkg.sv
      - logic/alu.sv
      - logic/register_file.sv
      - core/control_fsm.sv
      - core/mips_core.sv
      - logic/unified_memory.sv
      - logic/mips_system.sv
  - target: simulation
    files:
      - tb/mips_properties.sv
      - tb/mips_checker.sv
      - tb/tb_mips_system.sv
